// ==== dv/tb_rv_front.sv ====
// RV32I front end testbench
`timescale 1ns/1ps
`include "rv_front_config.svh"

module tb_rv_front import rv_front_pkg::*; ();

    localparam int CLK_NS      = 4;
    localparam int WATCHDOG_NS = 2 * (64 * 4 * CLK_NS + 10 * CLK_NS);

    logic                clk = 1'b0;
    logic                arst_n;
    logic                ce;
    logic                redirect_valid;
    logic [`RV_XLEN-1:0] redirect_pc;
    logic [`RV_XLEN-1:0] imem_addr;
    logic [`RV_XLEN-1:0] imem_data;
    wb_req_s             wb;
    dispatch_rec_s       dispatch;

    logic [31:0]   imem [64];
    logic [31:0]   shadow [32];              // Expected register contents
    logic [31:0]   seed = 32'hc7bf_d981;
    logic [31:0]   pc_ref;                   // Expected fetch address
    logic [5:0]    n_fix;
    logic [3:0]    tag_ref;
    logic          last_pushed;
    logic          edge_en = 1'b0;           // ce as seen by the last rising edge
    int            n_checked;
    string         test_name;
    dispatch_rec_s exp_q[$];
    dispatch_rec_s exp_rec;
    dispatch_rec_s last_disp = '0;

    rv_front_top rv_front_top_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .ce             (ce),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .wb             (wb),
        .dispatch       (dispatch)
    );

    always #(CLK_NS / 2) clk = ~clk;

    assign imem_data = imem[imem_addr[7:2]];    // Same cycle answer that wraps at 256 bytes

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected dispatch record from the RV32I encoding rules
    function automatic dispatch_rec_s decode_ref(input logic [31:0] pc, input logic [31:0] w,
                                                 input logic [3:0] tag);
        dispatch_rec_s r;
        logic [6:0]    opc;
        logic [2:0]    f3;
        logic          alt;
        logic          known;
        opc = w[6:0];
        f3 = w[14:12];
        alt = (w[31:25] == 7'h20);
        known = 1'b0;
        r = '0;
        r.valid = 1'b1;
        r.pc = pc;
        r.npc = pc + 32'd4;
        r.tag = tag;
        r.rd = w[11:7];
        r.rs1_val = shadow[w[19:15]];
        r.rs2_val = shadow[w[24:20]];
        r.unit = UNIT_BYPASS;
        r.unit_op = OP0;
        if (w == 32'h0000_0013 || w == 32'h0000_0000) begin
            known = 1'b1;                           // Both NOP forms stay on bypass
        end else begin
            case (opc)
                7'h37: begin
                    known = 1'b1;
                    r.unit_op = OP1;
                end
                7'h17: begin
                    known = 1'b1;
                    r.unit = UNIT_ADDER;
                end
                7'h6f: begin
                    known = 1'b1;
                    r.unit = UNIT_BRANCH;
                    r.unit_op = OP6;
                end
                7'h67: begin
                    known = (f3 == 3'd0);
                    if (known) begin
                        r.unit = UNIT_BRANCH;
                        r.unit_op = OP7;
                    end
                end
                7'h63: begin
                    known = (f3 != 3'd2 && f3 != 3'd3);
                    if (known) r.unit = UNIT_BRANCH;
                    case (f3)
                        3'd1: r.unit_op = OP1;
                        3'd4: r.unit_op = OP2;
                        3'd6: r.unit_op = OP3;
                        3'd5: r.unit_op = OP4;
                        3'd7: r.unit_op = OP5;
                        default: r.unit_op = OP0;
                    endcase
                end
                7'h03: begin
                    known = (f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7);
                    if (known) r.unit = UNIT_MEMORY;
                    case (f3)
                        3'd4: r.unit_op = OP1;
                        3'd1: r.unit_op = OP2;
                        3'd5: r.unit_op = OP3;
                        3'd2: r.unit_op = (known) ? OP4 : OP0;
                        default: r.unit_op = OP0;
                    endcase
                end
                7'h23: begin
                    known = (f3 <= 3'd2);
                    if (known) begin
                        r.unit = UNIT_MEMORY;
                        r.unit_op = (f3 == 3'd0) ? OP7 : (f3 == 3'd1) ? OP6 : OP5;
                    end
                end
                7'h13, 7'h33: begin
                    // funct7 only matters for register ops and shifts
                    known = (opc == 7'h13 && f3 != 3'd1 && f3 != 3'd5) || w[31:25] == 7'h00
                            || (alt && (f3 == 3'd5 || (f3 == 3'd0 && opc == 7'h33)));
                    if (known) begin
                        case (f3)
                            3'd0: begin
                                r.unit = UNIT_ADDER;
                                r.unit_op = (alt && opc == 7'h33) ? OP1 : OP0;
                            end
                            3'd1: r.unit = UNIT_SHIFTER;
                            3'd2: begin
                                r.unit = UNIT_ADDER;
                                r.unit_op = OP3;
                            end
                            3'd3: begin
                                r.unit = UNIT_ADDER;
                                r.unit_op = OP2;
                            end
                            3'd4: r.unit = UNIT_LOGICAL;
                            3'd5: begin
                                r.unit = UNIT_SHIFTER;
                                r.unit_op = alt ? OP2 : OP1;
                            end
                            3'd6: begin
                                r.unit = UNIT_LOGICAL;
                                r.unit_op = OP1;
                            end
                            default: begin
                                r.unit = UNIT_LOGICAL;
                                r.unit_op = OP2;
                            end
                        endcase
                    end
                end
                default: known = 1'b0;
            endcase
        end
        r.invalid = !known;
        case (opc)
            7'h13, 7'h67, 7'h03: r.fmt = FMT_I;
            7'h23:               r.fmt = FMT_S;
            7'h63:               r.fmt = FMT_B;
            7'h37, 7'h17:        r.fmt = FMT_U;
            7'h6f:               r.fmt = FMT_J;
            default:             r.fmt = FMT_R;
        endcase
        case (r.fmt)
            FMT_I:   r.imm = 32'($signed(w[31:20]));
            FMT_S:   r.imm = 32'($signed({w[31:25], w[11:7]}));
            FMT_B:   r.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            FMT_U:   r.imm = {w[31:12], 12'h000};
            FMT_J:   r.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            default: r.imm = 32'd0;
        endcase
        return r;
    endfunction

    task automatic check_value(input string field, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %0h actual %0h", test_name, field, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch on %s", field);
        end
    endtask

    task automatic add_word(input logic [31:0] w);
        imem[n_fix] = w;
        n_fix = n_fix + 6'd1;
    endtask

    // One falling edge of stimulus with the scoreboard tracking the expected PC
    task automatic step(input logic ce_v, input logic redir_v, input logic [31:0] rpc);
        @(negedge clk);
        check_value("imem_addr", 256'(pc_ref), 256'(imem_addr));
        ce = ce_v;
        redirect_valid = redir_v;
        redirect_pc = rpc;
        if (ce_v && redir_v) begin
            if (last_pushed) void'(exp_q.pop_back());   // Word in the fetch register dies
            last_pushed = 1'b0;
            pc_ref = rpc;
        end else if (ce_v) begin
            exp_q.push_back(decode_ref(pc_ref, imem[pc_ref[7:2]], tag_ref));
            pc_ref = pc_ref + 32'd4;
            tag_ref = tag_ref + 4'd1;
            last_pushed = 1'b1;
        end
    endtask

    always @(posedge clk) edge_en <= ce;

    always @(negedge clk) begin
        if (edge_en && dispatch.valid) begin
            if (exp_q.size() == 0) begin
                $display("dispatch valid with no instruction expected in flight");
                $display("Simulation FAILED");
                $fatal(1, "unexpected dispatch record");
            end else begin
                exp_rec = exp_q.pop_front();
                check_value("pc", 256'(exp_rec.pc), 256'(dispatch.pc));
                check_value("npc", 256'(exp_rec.npc), 256'(dispatch.npc));
                check_value("tag", 256'(exp_rec.tag), 256'(dispatch.tag));
                check_value("unit", 256'(exp_rec.unit), 256'(dispatch.unit));
                check_value("unit_op", 256'(exp_rec.unit_op), 256'(dispatch.unit_op));
                check_value("fmt", 256'(exp_rec.fmt), 256'(dispatch.fmt));
                check_value("invalid", 256'(exp_rec.invalid), 256'(dispatch.invalid));
                check_value("rd", 256'(exp_rec.rd), 256'(dispatch.rd));
                check_value("rs1_val", 256'(exp_rec.rs1_val), 256'(dispatch.rs1_val));
                check_value("rs2_val", 256'(exp_rec.rs2_val), 256'(dispatch.rs2_val));
                check_value("imm", 256'(exp_rec.imm), 256'(dispatch.imm));
                n_checked++;
            end
        end else if (!edge_en) begin
            check_value("hold", 256'(last_disp), 256'(dispatch));  // Stalled edge
        end
        last_disp = dispatch;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired before the test sequence finished");
    end

    initial begin
        arst_n = 1'b0;
        ce = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        wb = '0;
        pc_ref = `RV_RESET_PC;
        tag_ref = 4'd0;
        last_pushed = 1'b0;
        n_checked = 0;
        test_name = "reset";
        for (int i = 0; i < 32; i++) shadow[i[4:0]] = 32'd0;
        for (int i = 0; i < 64; i++) begin
            seed = lcg_next(seed);
            imem[i[5:0]] = seed;                     // Random words past the fixed list
        end
        n_fix = 6'd0;
        add_word(32'h0000_0013);
        add_word(32'h0000_0000);
        add_word(32'h1234_50B7);                     // LUI
        add_word(32'hFFFF_F117);                     // AUIPC
        add_word(32'h0080_00EF);
        add_word(32'hFF9F_F0EF);                     // JAL backwards
        add_word({12'h004, 5'd2, 3'd0, 5'd1, 7'h67});
        add_word({12'hFF0, 5'd2, 3'd1, 5'd1, 7'h67}); // JALR with bad funct3
        add_word({12'h800, 5'd1, 3'd0, 5'd3, 7'h13});
        add_word({7'h20, 5'd3, 5'd1, 3'd5, 5'd8, 7'h13});
        add_word({7'h55, 5'd2, 5'd1, 3'd1, 5'd3, 7'h13});
        add_word({7'h00, 5'd0, 5'd0, 3'd4, 5'd9, 7'h33}); // Reads x0 twice
        add_word(32'h0000_0073);                     // ECALL
        add_word(32'h0FF0_000F);                     // FENCE
        add_word(32'h3401_1073);                     // CSRRW
        for (int f = 0; f < 8; f++) begin
            add_word({7'h00, 5'd5, 5'd1, f[2:0], 5'd3, 7'h13});
            add_word({7'h00, 5'd2, 5'd1, f[2:0], 5'd9, 7'h33});
            add_word({7'h20, 5'd2, 5'd1, f[2:0], 5'd9, 7'h33});
            add_word({7'h7e, 5'd2, 5'd1, f[2:0], 5'd25, 7'h63});
            add_word({7'h7f, 5'd28, 5'd2, f[2:0], 5'd10, 7'h03});
        end
        for (int f = 0; f < 4; f++) add_word({7'h40, 5'd3, 5'd4, f[2:0], 5'd17, 7'h23});
        repeat (10) @(negedge clk);
        arst_n = 1'b1;

        test_name = "regs";
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            seed = lcg_next(seed);
            wb.en = 1'b1;
            wb.rd = r[4:0];
            wb.data = seed | 32'd1;                  // Nonzero so an x0 write would show
            if (r != 0) shadow[r[4:0]] = wb.data;
        end
        @(negedge clk);
        wb.en = 1'b0;

        test_name = "stream";
        for (int i = 0; i < 100; i++) begin
            seed = lcg_next(seed);
            step(seed[9:8] != 2'b00, 1'b0, 32'd0);
        end

        test_name = "redirect";
        for (int k = 0; k < 4; k++) begin
            seed = lcg_next(seed);
            step(1'b1, 1'b1, {24'h0, seed[7:2], 2'b00});
            for (int i = 0; i < 10; i++) begin
                seed = lcg_next(seed);
                step(seed[9:8] != 2'b00, 1'b0, 32'd0);
            end
        end
        repeat (2) step(1'b0, 1'b0, 32'd0);

        if (n_checked >= 64 && exp_q.size() <= 2) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("only %0d records dispatched, %0d still expected", n_checked, exp_q.size());
            $display("Simulation FAILED");
            $fatal(1, "dispatch stream incomplete");
        end
    end

endmodule

// ==== hw/instr_decoder.sv ====
// Instruction decode stage
`timescale 1ns/1ps
`include "rv_front_config.svh"

module instr_decoder import rv_front_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        ce,
    input  logic        flush,
    input  fetch_rec_s  fetch,
    output decode_rec_s decode
);

    logic [`RV_XLEN-1:0] word;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    instr_op_e           op;
    exec_unit_e          unit;
    unit_op_e            unit_op;
    instr_fmt_e          fmt;
    decode_rec_s         decode_q;

    assign word   = fetch.instr;
    assign opcode = word[6:0];
    assign funct3 = word[14:12];
    assign funct7 = word[31:25];

    always_comb begin
        op = INVALID;
        if (word == 32'h0000_0000 || word == 32'h0000_0013) begin
            op = NOP;                   // Canonical NOP words win over ADDI
        end else begin
            case (opcode)
                7'b0110111: op = LUI;
                7'b0010111: op = ADD;   // AUIPC
                7'b1101111: op = JAL;
                7'b1100111: op = (funct3 == 3'b000) ? JALR : INVALID;
                7'b1100011: begin
                    case (funct3)
                        3'b000:  op = BEQ;
                        3'b001:  op = BNE;
                        3'b100:  op = BLT;
                        3'b101:  op = BGE;
                        3'b110:  op = BLTU;
                        3'b111:  op = BGEU;
                        default: op = INVALID;
                    endcase
                end
                7'b0000011: begin
                    case (funct3)
                        3'b000:  op = LB;
                        3'b001:  op = LH;
                        3'b010:  op = LW;
                        3'b100:  op = LBU;
                        3'b101:  op = LHU;
                        default: op = INVALID;
                    endcase
                end
                7'b0100011: begin
                    case (funct3)
                        3'b000:  op = SB;
                        3'b001:  op = SH;
                        3'b010:  op = SW;
                        default: op = INVALID;
                    endcase
                end
                7'b0010011: begin
                    case (funct3)
                        3'b000:  op = ADD;  // ADDI
                        3'b010:  op = SLT;
                        3'b011:  op = SLTU;
                        3'b100:  op = XOR;
                        3'b110:  op = OR;
                        3'b111:  op = AND;
                        3'b001:  op = (funct7 == 7'h00) ? SLL : INVALID;
                        default: begin
                            if (funct7 == 7'h00) op = SRL;
                            else if (funct7 == 7'h20) op = SRA;
                        end
                    endcase
                end
                7'b0110011: begin
                    case ({funct7, funct3})
                        {7'h00, 3'b000}: op = ADD;
                        {7'h20, 3'b000}: op = SUB;
                        {7'h00, 3'b001}: op = SLL;
                        {7'h00, 3'b010}: op = SLT;
                        {7'h00, 3'b011}: op = SLTU;
                        {7'h00, 3'b100}: op = XOR;
                        {7'h00, 3'b101}: op = SRL;
                        {7'h20, 3'b101}: op = SRA;
                        {7'h00, 3'b110}: op = OR;
                        {7'h00, 3'b111}: op = AND;
                        default:         op = INVALID;
                    endcase
                end
                default: op = INVALID;  // CSR, FENCE, ECALL land here too
            endcase
        end
    end

    always_comb begin
        case (op)
            ADD, SUB, SLTU, SLT:                       unit = UNIT_ADDER;
            XOR, OR, AND:                              unit = UNIT_LOGICAL;
            SLL, SRL, SRA:                             unit = UNIT_SHIFTER;
            BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR: unit = UNIT_BRANCH;
            LB, LBU, LH, LHU, LW, SB, SH, SW:          unit = UNIT_MEMORY;
            default:                                   unit = UNIT_BYPASS;
        endcase
    end

    always_comb begin
        case (op)
            ADD, XOR, SLL, BEQ, LB:      unit_op = OP0;
            SUB, OR, SRL, BNE, LBU, LUI: unit_op = OP1;
            SLTU, AND, SRA, BLT, LH:     unit_op = OP2;
            SLT, BLTU, LHU:              unit_op = OP3;
            BGE, LW:                     unit_op = OP4;
            BGEU, SW:                    unit_op = OP5;
            JAL, SH:                     unit_op = OP6;
            JALR, SB:                    unit_op = OP7;
            default:                     unit_op = OP0;
        endcase
    end

    always_comb begin
        case (opcode)
            7'b0010011, 7'b1100111, 7'b0000011: fmt = FMT_I;
            7'b0100011:                         fmt = FMT_S;
            7'b1100011:                         fmt = FMT_B;
            7'b0110111, 7'b0010111:             fmt = FMT_U;
            7'b1101111:                         fmt = FMT_J;
            default:                            fmt = FMT_R;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decode_q <= '0;
        end else if (ce) begin
            decode_q.valid   <= fetch.valid && !flush;  // Redirect kills it
            decode_q.pc      <= fetch.pc;
            decode_q.npc     <= fetch.npc;
            decode_q.instr   <= word;
            decode_q.tag     <= fetch.tag;
            decode_q.fmt     <= fmt;
            decode_q.unit    <= unit;
            decode_q.unit_op <= unit_op;
            decode_q.invalid <= (op == INVALID);
        end
    end

    assign decode = decode_q;

    // Back end relies on bypass to pass unknown words harmlessly
    a_invalid_bypass: assert property (@(posedge clk) disable iff (!arst_n)
        decode.invalid |-> decode.unit == UNIT_BYPASS && decode.unit_op == OP0)
        else $error("invalid record without bypass unit");

endmodule

// ==== hw/instr_fetch.sv ====
// Instruction fetch stage
`timescale 1ns/1ps
`include "rv_front_config.svh"

module instr_fetch import rv_front_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ce,
    input  logic                redirect_valid,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_data,
    output fetch_rec_s          fetch
);

    logic [`RV_XLEN-1:0]  pc;
    logic [`RV_XLEN-1:0]  pc_seq;
    logic [`RV_TAG_W-1:0] tag;
    fetch_rec_s           fetch_q;

    assign pc_seq    = pc + 'd4;       // Sequential successor
    assign imem_addr = pc;             // Memory answers in the same cycle

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= `RV_RESET_PC;
            tag     <= '0;
            fetch_q <= '0;
        end else if (ce) begin
            if (redirect_valid) begin
                pc            <= redirect_pc;
                fetch_q.valid <= 1'b0;  // Word at old PC is dropped
            end else begin
                pc            <= pc_seq;
                tag           <= tag + 1'b1;
                fetch_q.valid <= 1'b1;
                fetch_q.pc    <= pc;
                fetch_q.npc   <= pc_seq;
                fetch_q.instr <= imem_data;
                fetch_q.tag   <= tag;
            end
        end
    end

    assign fetch = fetch_q;

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        imem_addr[1:0] == 2'b00)
        else $error("imem_addr not word aligned");

endmodule

// ==== hw/operand_fetch.sv ====
// Operand fetch stage
`timescale 1ns/1ps
`include "rv_front_config.svh"

module operand_fetch import rv_front_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          ce,
    input  decode_rec_s   decode,
    input  wb_req_s       wb,
    output dispatch_rec_s dispatch
);

    logic [`RV_XLEN-1:0] word;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [4:0]          rd_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] imm;
    dispatch_rec_s       dispatch_q;

    assign word     = decode.instr;
    assign rs1_addr = word[19:15];
    assign rs2_addr = word[24:20];
    assign rd_addr  = word[11:7];

    reg_file reg_file_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb       (wb),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Immediate layout per format with bit 31 as the sign
    always_comb begin
        case (decode.fmt)
            FMT_I:   imm = {{20{word[31]}}, word[31:20]};
            FMT_S:   imm = {{20{word[31]}}, word[31:25], word[11:7]};
            FMT_B:   imm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
            FMT_U:   imm = {word[31:12], 12'b0};
            FMT_J:   imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
            default: imm = '0;          // R format has none
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dispatch_q <= '0;
        end else if (ce) begin
            dispatch_q.valid   <= decode.valid;
            dispatch_q.pc      <= decode.pc;
            dispatch_q.npc     <= decode.npc;
            dispatch_q.tag     <= decode.tag;
            dispatch_q.unit    <= decode.unit;
            dispatch_q.unit_op <= decode.unit_op;
            dispatch_q.fmt     <= decode.fmt;
            dispatch_q.invalid <= decode.invalid;
            dispatch_q.rd      <= rd_addr;
            dispatch_q.rs1_val <= rs1_data;   // Sees writes from earlier edges
            dispatch_q.rs2_val <= rs2_data;
            dispatch_q.imm     <= imm;
        end
    end

    assign dispatch = dispatch_q;

endmodule

// ==== hw/reg_file.sv ====
// Integer register file
`timescale 1ns/1ps
`include "rv_front_config.svh"

module reg_file import rv_front_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  wb_req_s             wb,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // x0 is cleared by reset and never written, so it reads zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;     // Independent of stage enable
        end
    end

    assign rs1_data = regs[rs1_addr];   // Asynchronous reads
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== hw/rv_front_config.svh ====
// RV32I front end configuration
`ifndef RV_FRONT_CONFIG_SVH
`define RV_FRONT_CONFIG_SVH

`define RV_XLEN     32              // Data and address width
`define RV_NREGS    32              // Architectural registers
`define RV_RESET_PC 32'h0000_0000   // First fetch address
`define RV_TAG_W    4               // Wrapping instruction tag

`endif

// ==== hw/rv_front_pkg.sv ====
// RV32I front end types
`include "rv_front_config.svh"

package rv_front_pkg;

    // Operation codes as seen by the decoder
    typedef enum logic [5:0] {
        NOP, LUI, ADD, SUB, SLTU, SLT, XOR, OR, AND, SLL, SRL, SRA,
        BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        INVALID
    } instr_op_e;

    typedef enum logic [2:0] {
        UNIT_ADDER, UNIT_LOGICAL, UNIT_SHIFTER, UNIT_BRANCH, UNIT_MEMORY, UNIT_BYPASS
    } exec_unit_e;

    typedef enum logic [2:0] {OP0, OP1, OP2, OP3, OP4, OP5, OP6, OP7} unit_op_e;

    typedef enum logic [2:0] {FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J} instr_fmt_e;

    typedef struct packed {
        logic                 valid;
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  npc;
        logic [`RV_XLEN-1:0]  instr;
        logic [`RV_TAG_W-1:0] tag;
    } fetch_rec_s;

    typedef struct packed {
        logic                 valid;
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  npc;
        logic [`RV_XLEN-1:0]  instr;     // Raw word, operand fetch slices it
        logic [`RV_TAG_W-1:0] tag;
        instr_fmt_e           fmt;
        exec_unit_e           unit;
        unit_op_e             unit_op;
        logic                 invalid;
    } decode_rec_s;

    typedef struct packed {
        logic                 valid;
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  npc;
        logic [`RV_TAG_W-1:0] tag;
        exec_unit_e           unit;
        unit_op_e             unit_op;
        instr_fmt_e           fmt;
        logic                 invalid;
        logic [4:0]           rd;
        logic [`RV_XLEN-1:0]  rs1_val;
        logic [`RV_XLEN-1:0]  rs2_val;
        logic [`RV_XLEN-1:0]  imm;       // Sign extended per format
    } dispatch_rec_s;

    typedef struct packed {
        logic                en;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } wb_req_s;

endpackage

// ==== hw/rv_front_top.sv ====
// RV32I front end top level
`timescale 1ns/1ps
`include "rv_front_config.svh"

module rv_front_top import rv_front_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ce,
    input  logic                redirect_valid,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_data,
    input  wb_req_s             wb,
    output dispatch_rec_s       dispatch
);

    fetch_rec_s  fetch_rec;
    decode_rec_s decode_rec;

    instr_fetch instr_fetch_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .ce             (ce),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .fetch          (fetch_rec)
    );

    instr_decoder instr_decoder_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .ce     (ce),
        .flush  (redirect_valid),   // Kills the word leaving fetch
        .fetch  (fetch_rec),
        .decode (decode_rec)
    );

    operand_fetch operand_fetch_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .ce       (ce),
        .decode   (decode_rec),
        .wb       (wb),
        .dispatch (dispatch)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the run by the pass line in its output
verilator --binary --timing --assert -f tb.f --top-module tb_rv_front -o tb_rv_front \
    && ./obj_dir/tb_rv_front | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

// ==== tb.f ====
+incdir+hw
hw/rv_front_pkg.sv
hw/instr_fetch.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/operand_fetch.sv
hw/rv_front_top.sv
dv/tb_rv_front.sv
